//--- Bender.yml
package:
  name: spi_block

sources:
  - spiBusPkg.sv
  - spiRegPkg.sv
  - spiCsr.sv
  - spiShifter.sv
  - spiBlock.sv
  - target: test
    files:
      - spiBlock_properties.sv
      - tbSpiBlock.sv

//--- files.f
spiBusPkg.sv
spiRegPkg.sv
spiCsr.sv
spiShifter.sv
spiBlock.sv
spiBlock_properties.sv
tbSpiBlock.sv

//--- spiBlock.sv
// SPI master block
// Register file on the control bus driving a mode 0 byte engine.
// Chip select, serial clock and data pins plus a done interrupt.

`timescale 1ns/1ps
`default_nettype none

module spiBlock
	import spiBusPkg::*;
	import spiRegPkg::*;
#(
	parameter blockSel_t blockAdrs = 8'h03
)(
	input  wire             sysClk,
	input  wire             reset,
	// Control bus
	input  wire             reqValid,
	input  wire             reqWrite,
	input  wire  busAdrs_t  reqAdrs,
	input  wire  busData_t  reqWd,
	output logic            reqReady,
	input  wire             rspReady,
	output logic            rspValid,
	output busData_t        rspRd,
	// SPI pins
	output logic            spiSck,
	output logic            spiMosi,
	input  wire             spiMiso,
	output logic            spiCs,
	output logic            spiIntr
);

	//----------------------------------------------------------------------
	// Register file to engine
	//----------------------------------------------------------------------
	logic     start;
	spiByte_t txData;
	clkDiv_t  clkDiv;
	logic     busy;
	logic     done;
	spiByte_t rxData;

	spiCsr #(
		.blockAdrs (blockAdrs)
	) i_spiCsr (
		.sysClk    (sysClk),
		.reset     (reset),
		.reqValid  (reqValid),
		.reqWrite  (reqWrite),
		.reqAdrs   (reqAdrs),
		.reqWd     (reqWd),
		.reqReady  (reqReady),
		.rspReady  (rspReady),
		.rspValid  (rspValid),
		.rspRd     (rspRd),
		.busy      (busy),
		.done      (done),
		.rxData    (rxData),
		.start     (start),
		.txData    (txData),
		.clkDiv    (clkDiv),
		.spiCs     (spiCs),
		.spiIntr   (spiIntr)
	);

	spiShifter i_spiShifter (
		.sysClk    (sysClk),
		.reset     (reset),
		.start     (start),
		.txData    (txData),
		.clkDiv    (clkDiv),
		.miso      (spiMiso),
		.busy      (busy),
		.done      (done),
		.rxData    (rxData),
		.sck       (spiSck),
		.mosi      (spiMosi)
	);

endmodule

`default_nettype wire

//--- spiBlock_properties.sv
// SPI block bus and pin rules
// Response hold, one transaction in flight and idle serial clock,
// bound into the top level of the SPI master

`timescale 1ns/1ps
`default_nettype none

module spiBlock_properties
	import spiBusPkg::*;
(
	input wire             sysClk,
	input wire             reset,
	input wire             reqReady,
	input wire             rspValid,
	input wire             rspReady,
	input wire  busData_t  rspRd,
	input wire             spiSck,
	input wire             busy		// Engine busy inside the block
);

	int assertFails = 0;		// Failed assertion count

	// Parked response keeps its data
	rspHold: assert property (@(posedge sysClk) disable iff (reset)
		rspValid && !rspReady |=> rspValid && $stable(rspRd))
		else
		begin
			$error("rspValid dropped or rspRd changed before rspReady");
			assertFails = assertFails + 1;
		end

	readyLow: assert property (@(posedge sysClk) disable iff (reset)
		rspValid |-> !reqReady)
		else
		begin
			$error("reqReady high while a response is pending");
			assertFails = assertFails + 1;
		end

	sckIdle: assert property (@(posedge sysClk) disable iff (reset)
		!busy |-> !spiSck)		// Mode 0 clock idles low
		else
		begin
			$error("spiSck high while the engine is idle");
			assertFails = assertFails + 1;
		end

endmodule

bind spiBlock spiBlock_properties i_spiBlockProperties (
	.sysClk   (sysClk),
	.reset    (reset),
	.reqReady (reqReady),
	.rspValid (rspValid),
	.rspReady (rspReady),
	.rspRd    (rspRd),
	.spiSck   (spiSck),
	.busy     (busy)
);

`default_nettype wire

//--- spiBusPkg.sv
// Control bus types
// Address and data words of the on-chip control bus, plus the
// split of an address into block select and register offset

`default_nettype none

package spiBusPkg;

	//----------------------------------------------------------------------
	// Field widths
	//----------------------------------------------------------------------
	localparam int busAdrsW  = 16;		// Full bus address
	localparam int busDataW  = 32;		// Read and write data
	localparam int blockSelW = 8;		// Upper address byte
	localparam int regOfsW   = busAdrsW - blockSelW;	// Lower address byte

	//----------------------------------------------------------------------
	// Bus types
	//----------------------------------------------------------------------
	// Block select in [15:8], register offset in [7:0]
	typedef logic [busAdrsW-1:0]  busAdrs_t;

	typedef logic [busDataW-1:0]  busData_t;	// One bus word

	// Compared against the block's own address
	typedef logic [blockSelW-1:0] blockSel_t;

	// Offset inside a block
	typedef logic [regOfsW-1:0]   regOfs_t;

	// Zero word for misses and write responses
	localparam busData_t busZero = '0;

endpackage

`default_nettype wire

//--- spiCsr.sv
// SPI master register file
// Bus slave with a one-deep valid/ready request and response handshake.
// Decodes block and offset, holds control, divider and transmit
// registers and the sticky done flag, and issues transfer starts.

`timescale 1ns/1ps
`default_nettype none

module spiCsr
	import spiBusPkg::*;
	import spiRegPkg::*;
#(
	parameter blockSel_t blockAdrs = 8'h03		// Upper address byte of this block
)(
	input  wire              sysClk,
	input  wire              reset,
	// Request channel
	input  wire              reqValid,
	input  wire              reqWrite,
	input  wire  busAdrs_t   reqAdrs,
	input  wire  busData_t   reqWd,
	output logic             reqReady,
	// Response channel
	input  wire              rspReady,
	output logic             rspValid,
	output busData_t         rspRd,
	// Shift engine
	input  wire              busy,
	input  wire              done,			// One-cycle end of byte
	input  wire  spiByte_t   rxData,
	output logic             start,
	output spiByte_t         txData,
	output clkDiv_t          clkDiv,
	// Pins
	output logic             spiCs,			// Active low
	output logic             spiIntr
);

	//----------------------------------------------------------------------
	// Decode
	//----------------------------------------------------------------------
	blockSel_t reqBlock;
	regOfs_t   reqOfs;
	logic      readyEn;		// Low for one cycle out of reset
	logic      accept;
	logic      hit;
	logic      wrHit;		// Accepted write to this block
	logic      txWrite;		// regTx write that may start
	logic      ctrlEn;
	logic      ctrlCs;
	logic      doneFlag;	// Sticky until cleared by write
	busData_t  readData;

	assign reqBlock = reqAdrs[busAdrsW-1 -: blockSelW];
	assign reqOfs   = reqAdrs[regOfsW-1:0];
	assign hit      = (reqBlock == blockAdrs);
	assign reqReady = readyEn & ~rspValid;	// One transaction in flight
	assign accept   = reqValid & reqReady;
	assign wrHit    = accept & reqWrite & hit;

	// Refuse starts the engine could not take
	assign txWrite  = wrHit & (reqOfs == regTx) & ctrlEn & ~busy;

	// Read data from current register contents
	always_comb
	begin
		readData = busZero;
		if (hit)
		begin
			case (reqOfs)
				regCtrl:
				begin
					readData[ctrlEnBit] = ctrlEn;
					readData[ctrlCsBit] = ctrlCs;
				end
				regDiv:    readData[clkDivW-1:0]  = clkDiv;
				regRx:     readData[spiByteW-1:0] = rxData;
				regStatus:
				begin
					readData[statBusyBit] = busy;
					readData[statDoneBit] = doneFlag;
				end
				default:   readData = busZero;		// regTx and holes
			endcase
		end
	end

	//----------------------------------------------------------------------
	// Handshake
	//----------------------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			readyEn  <= 1'b0;
			rspValid <= 1'b0;
		end
		else
		begin
			readyEn <= 1'b1;
			if (accept)
				rspValid <= 1'b1;		// Response one cycle later
			else if (rspReady)
				rspValid <= 1'b0;
		end
	end

	// Captured once, held while waiting on rspReady
	always_ff @(posedge sysClk)
	begin
		if (accept)
			rspRd <= reqWrite ? busZero : readData;
	end

	//----------------------------------------------------------------------
	// Control registers
	//----------------------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			ctrlEn   <= 1'b0;
			ctrlCs   <= 1'b0;
			clkDiv   <= '0;
			doneFlag <= 1'b0;
			start    <= 1'b0;
		end
		else
		begin
			start <= txWrite;		// Pulse in cycle after acceptance
			if (wrHit && reqOfs == regCtrl)
			begin
				ctrlEn <= reqWd[ctrlEnBit];
				ctrlCs <= reqWd[ctrlCsBit];
			end
			if (wrHit && reqOfs == regDiv)
				clkDiv <= reqWd[clkDivW-1:0];
			// Set wins over a clear in the same cycle
			if (done)
				doneFlag <= 1'b1;
			else if (wrHit && reqOfs == regStatus && reqWd[statDoneBit])
				doneFlag <= 1'b0;
		end
	end

	// Byte to send, loaded only with a real start
	always_ff @(posedge sysClk)
	begin
		if (txWrite)
			txData <= reqWd[spiByteW-1:0];
	end

	assign spiCs   = ~ctrlCs;
	assign spiIntr = doneFlag;		// Level interrupt

endmodule

`default_nettype wire

//--- spiRegPkg.sv
// SPI register map and engine types
// Register offsets and field positions of the SPI master, the byte
// and divider types, and the state encoding of the shift engine

`default_nettype none

package spiRegPkg;

	//----------------------------------------------------------------------
	// Widths and types
	//----------------------------------------------------------------------
	localparam int spiByteW = 8;		// One SPI transfer
	localparam int clkDivW  = 16;		// Divider register

	typedef logic [spiByteW-1:0] spiByte_t;

	// Half period of sck is value + 1 sysClk cycles
	typedef logic [clkDivW-1:0]  clkDiv_t;

	//----------------------------------------------------------------------
	// Register offsets
	//----------------------------------------------------------------------
	localparam logic [7:0] regCtrl   = 8'h00;	// Enable, chip select
	localparam logic [7:0] regDiv    = 8'h04;	// Serial clock divider
	localparam logic [7:0] regTx     = 8'h08;	// Write only, starts transfer
	localparam logic [7:0] regRx     = 8'h0C;	// Read only, last received
	localparam logic [7:0] regStatus = 8'h10;	// Busy, sticky done

	//----------------------------------------------------------------------
	// Bit positions
	//----------------------------------------------------------------------
	localparam int ctrlEnBit   = 0;
	localparam int ctrlCsBit   = 1;		// 1 drives spiCs low
	localparam int statBusyBit = 0;
	localparam int statDoneBit = 1;		// Write 1 to clear

	//----------------------------------------------------------------------
	// Shift engine states
	//----------------------------------------------------------------------
	typedef enum logic [1:0]
	{
		idle    = 2'd0,			// sck low, waiting for start
		sckLow  = 2'd1,			// First half of a bit
		sckHigh = 2'd2			// Second half, miso captured on entry
	} shifterState_t;

endpackage

`default_nettype wire

//--- spiShifter.sv
// SPI mode 0 byte engine
// Clock idles low, miso captured on rising sck, mosi changes on
// falling sck, MSB first. The sck half period is clkDiv+1 cycles.

`timescale 1ns/1ps
`default_nettype none

module spiShifter
	import spiRegPkg::*;
(
	input  wire             sysClk,
	input  wire             reset,
	input  wire             start,		// One-cycle pulse, only while idle
	input  wire  spiByte_t  txData,
	input  wire  clkDiv_t   clkDiv,
	input  wire             miso,
	output logic            busy,
	output logic            done,		// One-cycle pulse at end of byte
	output spiByte_t        rxData,
	output logic            sck,
	output logic            mosi
);

	localparam int bitCntW = $clog2(spiByteW);

	//----------------------------------------------------------------------
	// Engine state
	//----------------------------------------------------------------------
	shifterState_t        state;
	clkDiv_t              halfCnt;		// Cycles into current half period
	clkDiv_t              divLat;		// Divider frozen for the byte
	logic [bitCntW-1:0]   bitCnt;		// Falling edges so far
	spiByte_t             shiftReg;		// Tx bits out at top, rx bits in at bottom
	logic                 misoBit;		// Sample from last rising edge
	logic                 halfEnd;
	logic                 lastBit;

	assign halfEnd = (halfCnt == divLat);
	assign lastBit = (bitCnt == bitCntW'(spiByteW - 1));
	assign mosi    = shiftReg[spiByteW-1];	// MSB first

	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			state    <= idle;
			halfCnt  <= '0;
			bitCnt   <= '0;
			shiftReg <= '0;
			rxData   <= '0;
			sck      <= 1'b0;
			busy     <= 1'b0;
			done     <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (done)
				busy <= 1'b0;		// Falls the cycle after done
			case (state)
				idle:
				begin
					sck <= 1'b0;
					if (start)
					begin
						state    <= sckLow;
						halfCnt  <= '0;
						bitCnt   <= '0;
						shiftReg <= txData;	// Bit 7 on mosi right away
						busy     <= 1'b1;
					end
				end

				sckLow:
				begin
					if (halfEnd)
					begin
						state   <= sckHigh;
						halfCnt <= '0;
						sck     <= 1'b1;	// Rising edge
					end
					else
						halfCnt <= halfCnt + 1'b1;
				end

				sckHigh:
				begin
					if (halfEnd)
					begin
						halfCnt <= '0;
						sck     <= 1'b0;	// Falling edge
						bitCnt  <= bitCnt + 1'b1;
						if (lastBit)
						begin
							// Eighth falling edge ends the byte
							state    <= idle;
							rxData   <= {shiftReg[spiByteW-2:0], misoBit};
							shiftReg <= '0;		// mosi idles low
							done     <= 1'b1;
						end
						else
						begin
							state    <= sckLow;
							shiftReg <= {shiftReg[spiByteW-2:0], misoBit};
						end
					end
					else
						halfCnt <= halfCnt + 1'b1;
				end

				default:
				begin
					state <= idle;
					sck   <= 1'b0;
				end
			endcase
		end
	end

	//----------------------------------------------------------------------
	// Capture paths
	//----------------------------------------------------------------------
	// miso taken on the edge that raises sck
	always_ff @(posedge sysClk)
	begin
		if (state == sckLow && halfEnd)
			misoBit <= miso;
	end

	always_ff @(posedge sysClk)
	begin
		if (state == idle && start)
			divLat <= clkDiv;	// Later divider writes wait for next byte
	end

endmodule

`default_nettype wire

//--- tbSpiBlock.sv
// SPI master block testbench
// Drives the control bus, models a mode 0 SPI slave on the pins and
// checks registers, transfers, chip select, done flag and back-pressure

`timescale 1ns/1ps
`default_nettype none

module tbSpiBlock
	import spiBusPkg::*;
	import spiRegPkg::*;
();

	//----------------------------------------------------------------------
	// Constants and signals
	//----------------------------------------------------------------------
	localparam blockSel_t blk         = 8'h03;	// DUT block address
	localparam int        drvDelay    = 1;		// Input skew after rising edge
	localparam int        busTimeout  = 50;		// Cycles per bus handshake wait
	localparam int        sigReqReady = 0;
	localparam int        sigRspValid = 1;
	localparam int        sigIntr     = 2;
	localparam busData_t  ctrlMask    = (1 << ctrlEnBit) | (1 << ctrlCsBit);
	localparam busData_t  busyMask    = 1 << statBusyBit;
	localparam busData_t  doneMask    = 1 << statDoneBit;

	logic        sysClk = 1'b0;
	logic        reset;
	logic        reqValid;
	logic        reqWrite;
	busAdrs_t    reqAdrs;
	busData_t    reqWd;
	logic        reqReady;
	logic        rspReady;
	logic        rspValid;
	busData_t    rspRd;
	logic        spiSck;
	logic        spiMosi;
	logic        spiMiso;
	logic        spiCs;
	logic        spiIntr;

	int          errorCount = 0;
	int          checkCount = 0;
	int          testCount  = 0;
	int          testErrors = 0;
	int          riseCnt    = 0;		// sck rising edges seen by the slave
	int unsigned seedState;
	string       testName;
	spiByte_t    slaveShift = '0;	// Slave transmit byte, top bit on miso
	spiByte_t    mosiCap    = '0;	// Bits taken from mosi

	spiBlock #(
		.blockAdrs (blk)
	) i_spiBlock (
		.sysClk    (sysClk),
		.reset     (reset),
		.reqValid  (reqValid),
		.reqWrite  (reqWrite),
		.reqAdrs   (reqAdrs),
		.reqWd     (reqWd),
		.reqReady  (reqReady),
		.rspReady  (rspReady),
		.rspValid  (rspValid),
		.rspRd     (rspRd),
		.spiSck    (spiSck),
		.spiMosi   (spiMosi),
		.spiMiso   (spiMiso),
		.spiCs     (spiCs),
		.spiIntr   (spiIntr)
	);

	always #50 sysClk = ~sysClk;		// 100 ns period

	//----------------------------------------------------------------------
	// SPI slave model, mode 0
	//----------------------------------------------------------------------
	always @(posedge spiSck)
	begin
		riseCnt = riseCnt + 1;
		if (spiCs === 1'b0)
			mosiCap = {mosiCap[spiByteW-2:0], spiMosi};	// MSB arrives first
	end

	always @(negedge spiSck)
	begin
		#drvDelay;
		slaveShift = {slaveShift[spiByteW-2:0], 1'b0};
		spiMiso    = slaveShift[spiByteW-1];	// Next bit before next rise
	end

	//----------------------------------------------------------------------
	// Reference and checks
	//----------------------------------------------------------------------
	// Returns {received byte, byte seen on mosi}
	function automatic logic [15:0] spiExpect(input spiByte_t txByte, input spiByte_t slaveByte);
		spiByte_t rxExp;
		spiByte_t mosiExp;
		rxExp   = '0;
		mosiExp = '0;
		for (int b = spiByteW - 1; b >= 0; b--)
		begin
			mosiExp = {mosiExp[spiByteW-2:0], txByte[b]};
			rxExp   = {rxExp[spiByteW-2:0], slaveByte[b]};	// Shifted in at bottom
		end
		return {rxExp, mosiExp};
	endfunction

	task automatic checkValue(input string what, input busData_t expected, input busData_t actual);
		checkCount = checkCount + 1;
		if (actual !== expected)
		begin
			$display("FAIL %s %s: expected 0x%h, actual 0x%h", testName, what, expected, actual);
			errorCount = errorCount + 1;
			testErrors = testErrors + 1;
		end
	endtask

	task automatic beginTest(input string name);
		testName   = name;
		testErrors = 0;
	endtask

	task automatic endTest();
		testCount = testCount + 1;
		if (testErrors == 0)
			$display("test %s: passed", testName);
		else
			$display("test %s: %0d check(s) failed", testName, testErrors);
	endtask

	//----------------------------------------------------------------------
	// Bus and wait tasks
	//----------------------------------------------------------------------
	// Polls mid-cycle, stops the run when the limit runs out
	task automatic waitSignal(input int which, input int limit);
		int    cycles;
		logic  seen;
		string name;
		cycles = 0;
		seen   = 1'b0;
		case (which)
			sigReqReady: name = "reqReady";
			sigRspValid: name = "rspValid";
			default:     name = "spiIntr";
		endcase
		while (!seen)
		begin
			@(negedge sysClk);
			case (which)
				sigReqReady: seen = (reqReady === 1'b1);
				sigRspValid: seen = (rspValid === 1'b1);
				default:     seen = (spiIntr === 1'b1);
			endcase
			cycles = cycles + 1;
			if (!seen && cycles >= limit)
			begin
				$display("ERROR: no %s after %0d cycles, run stopped", name, cycles);
				$display("Simulation failed");
				$finish;
			end
		end
	endtask

	task automatic idleCycles(input int n);
		repeat (n) @(posedge sysClk);
		#drvDelay;
	endtask

	// Entered and left just after a rising edge
	task automatic busXfer(input logic write, input blockSel_t blkSel, input logic [7:0] ofs,
		input busData_t wd, input int stall, output busData_t rd);
		reqValid = 1'b1;
		reqWrite = write;
		reqAdrs  = {blkSel, ofs};
		reqWd    = wd;
		rspReady = (stall == 0);
		waitSignal(sigReqReady, busTimeout);
		@(posedge sysClk);			// Accepted here
		#drvDelay;
		reqValid = 1'b0;
		waitSignal(sigRspValid, busTimeout);
		rd = rspRd;
		if (stall > 0)
		begin
			// Response parked, nothing else may get in
			repeat (stall)
			begin
				@(negedge sysClk);
				checkValue("rspValid held", 1, busData_t'(rspValid));
				checkValue("rspRd stable", rd, rspRd);
				checkValue("reqReady low", 0, busData_t'(reqReady));
			end
			@(posedge sysClk);
			#drvDelay;
			rspReady = 1'b1;
		end
		@(posedge sysClk);			// Response taken
		#drvDelay;
	endtask

	task automatic prepSlave(input spiByte_t slaveByte);
		slaveShift = slaveByte;
		spiMiso    = slaveByte[spiByteW-1];	// Bit 7 ready for first rise
		riseCnt    = 0;
		mosiCap    = '0;
	endtask

	task automatic launchTransfer(input spiByte_t txByte, output logic [15:0] expBytes);
		spiByte_t slaveByte;
		busData_t rd;
		slaveByte = spiByte_t'($urandom);
		expBytes  = spiExpect(txByte, slaveByte);
		prepSlave(slaveByte);
		busXfer(1'b1, blk, regTx, busData_t'(txByte), 0, rd);
	endtask

	task automatic finishTransfer(input int div, input logic [15:0] expBytes);
		busData_t rd;
		waitSignal(sigIntr, 16 * (div + 1) + 40);	// Byte is 16 half periods
		@(posedge sysClk);
		#drvDelay;
		checkValue("sck rising edges", 8, riseCnt);
		checkValue("mosi byte", busData_t'(expBytes[7:0]), busData_t'(mosiCap));
		busXfer(1'b0, blk, regRx, '0, 0, rd);
		checkValue("regRx", busData_t'(expBytes[15:8]), rd);
	endtask

	//----------------------------------------------------------------------
	// Test sequence
	//----------------------------------------------------------------------
	initial
	begin
		busData_t    rd;
		logic [15:0] expBytes;
		int          k;
		int          stall;

		seedState = $urandom(32'hf247_57f8);
		reset     = 1'b1;
		reqValid  = 1'b0;
		reqWrite  = 1'b0;
		reqAdrs   = '0;
		reqWd     = '0;
		rspReady  = 1'b1;
		spiMiso   = 1'b0;
		repeat (5) @(posedge sysClk);
		#drvDelay;
		reset = 1'b0;

		beginTest("registers");
		busXfer(1'b0, blk, regRx, '0, 0, rd);
		checkValue("regRx after reset", 0, rd);
		busXfer(1'b0, blk, regStatus, '0, 0, rd);
		checkValue("regStatus after reset", 0, rd);
		busXfer(1'b1, blk, regCtrl, 32'hffff_fffd, 0, rd);
		checkValue("write response", 0, rd);
		busXfer(1'b0, blk, regCtrl, '0, 0, rd);
		checkValue("regCtrl", ctrlMask & 32'hffff_fffd, rd);	// Only the two bits stick
		busXfer(1'b1, blk, regDiv, 32'hdead_1234, 0, rd);
		busXfer(1'b0, blk, regDiv, '0, 0, rd);
		checkValue("regDiv", 32'h0000_1234, rd);
		busXfer(1'b1, blk + 8'd1, regCtrl, '0, 0, rd);		// Other block
		busXfer(1'b0, blk, regCtrl, '0, 0, rd);
		checkValue("regCtrl after foreign write", 1, rd);
		busXfer(1'b0, blk + 8'd1, regDiv, '0, 0, rd);
		checkValue("foreign block read", 0, rd);
		busXfer(1'b0, blk, 8'h14, '0, 0, rd);
		checkValue("unmapped read", 0, rd);
		busXfer(1'b0, blk, regTx, '0, 0, rd);
		checkValue("regTx read", 0, rd);
		endTest();

		beginTest("transfer");
		busXfer(1'b1, blk, regCtrl, ctrlMask, 0, rd);
		for (k = 0; k < 6; k++)
		begin
			busXfer(1'b1, blk, regDiv, busData_t'(k), 0, rd);
			launchTransfer(spiByte_t'($urandom), expBytes);
			finishTransfer(k, expBytes);
			busXfer(1'b1, blk, regStatus, doneMask, 0, rd);	// Clear done
		end
		endTest();

		beginTest("chipSelect");
		busXfer(1'b1, blk, regCtrl, 1 << ctrlEnBit, 0, rd);
		checkValue("spiCs released", 1, busData_t'(spiCs));
		busXfer(1'b1, blk, regCtrl, ctrlMask, 0, rd);
		checkValue("spiCs asserted", 0, busData_t'(spiCs));
		busXfer(1'b1, blk, regDiv, '0, 0, rd);
		busXfer(1'b1, blk, regCtrl, 1 << ctrlCsBit, 0, rd);	// Select, no enable
		checkValue("spiCs without enable", 0, busData_t'(spiCs));
		prepSlave(8'h00);
		busXfer(1'b1, blk, regTx, 32'h0000_005a, 0, rd);
		idleCycles(40);		// Past a divider 0 byte
		checkValue("sck edges while disabled", 0, riseCnt);
		busXfer(1'b0, blk, regStatus, '0, 0, rd);
		checkValue("status while disabled", 0, rd);
		checkValue("spiIntr while disabled", 0, busData_t'(spiIntr));
		busXfer(1'b1, blk, regCtrl, '0, 0, rd);
		checkValue("spiCs idle", 1, busData_t'(spiCs));
		endTest();

		beginTest("doneIntr");
		busXfer(1'b1, blk, regCtrl, ctrlMask, 0, rd);
		busXfer(1'b1, blk, regDiv, 1, 0, rd);
		launchTransfer(8'hc3, expBytes);
		finishTransfer(1, expBytes);
		busXfer(1'b0, blk, regStatus, '0, 0, rd);
		checkValue("status done", doneMask, rd);
		checkValue("spiIntr set", 1, busData_t'(spiIntr));
		busXfer(1'b1, blk, regStatus, doneMask, 0, rd);
		busXfer(1'b0, blk, regStatus, '0, 0, rd);
		checkValue("status cleared", 0, rd);
		checkValue("spiIntr cleared", 0, busData_t'(spiIntr));
		endTest();

		beginTest("busyIgnore");
		busXfer(1'b1, blk, regDiv, 3, 0, rd);
		launchTransfer(8'h96, expBytes);
		busXfer(1'b0, blk, regStatus, '0, 0, rd);
		checkValue("busy during transfer", busyMask, rd);
		busXfer(1'b1, blk, regTx, 32'h0000_0069, 0, rd);	// Dropped
		finishTransfer(3, expBytes);
		idleCycles(80);
		checkValue("sck edges after ignored write", 8, riseCnt);
		busXfer(1'b1, blk, regStatus, doneMask, 0, rd);
		endTest();

		beginTest("backPressure");
		stall = 1 + $urandom % 6;
		busXfer(1'b1, blk, regDiv, 32'h0000_0042, stall, rd);
		checkValue("stalled write response", 0, rd);
		stall = 1 + $urandom % 6;
		busXfer(1'b0, blk, regDiv, '0, stall, rd);
		checkValue("stalled regDiv", 32'h0000_0042, rd);
		stall = 1 + $urandom % 6;
		busXfer(1'b0, blk, regCtrl, '0, stall, rd);
		checkValue("stalled regCtrl", ctrlMask, rd);
		stall = 1 + $urandom % 6;
		busXfer(1'b0, blk, regRx, '0, stall, rd);
		checkValue("stalled regRx", busData_t'(expBytes[15:8]), rd);	// Last busy test byte
		endTest();

		// Failed assertions of the bound checker
		errorCount = errorCount + i_spiBlock.i_spiBlockProperties.assertFails;
		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
